// File: Makefile
SRCS = list.f $(wildcard rtl/*.sv rtl/*.svh tests/*.sv tests/*.svh)

.PHONY: all run clean

all: obj_dir/Vtb_cdc

# rebuilt only when a source or the file list changes
obj_dir/Vtb_cdc: $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_cdc -f list.f

# the exit status follows the pass line in the simulator output
run: obj_dir/Vtb_cdc
	./obj_dir/Vtb_cdc | awk '{ print } /^Test OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: list.f
+incdir+rtl
+incdir+tests
rtl/cdc_data_pkg.sv
rtl/cdc_ctrl_pkg.sv
rtl/sync_ff.sv
rtl/cdc_src_half.sv
rtl/cdc_dst_half.sv
rtl/cdc_clear_seq.sv
rtl/cdc_2phase_clearable.sv
tests/tb_cdc.sv

// File: rtl/cdc_2phase_clearable.sv
// two-phase crossing for one word; src_valid_i must stay low while a clear is requested or pending
`timescale 1ns/1ps

module cdc_2phase_clearable
  import cdc_data_pkg::*;
  import cdc_ctrl_pkg::*;
(
  input  logic      src_clk_i,
  input  logic      src_rst_ni,
  input  logic      src_clear_i,
  input  logic      src_valid_i,
  input  cdc_word_t src_data_i,
  output logic      src_ready_o,
  output logic      src_clear_pending_o,

  input  logic      dst_clk_i,
  input  logic      dst_rst_ni,
  input  logic      dst_clear_i,
  input  logic      dst_ready_i,
  output cdc_word_t dst_data_o,
  output logic      dst_valid_o,
  output logic      dst_clear_pending_o
);

  logic       src_isolate;
  logic       src_clear;
  logic       src_isolate_ack_q;
  logic       src_clear_ack_q;
  logic       src_ready;
  logic       dst_isolate;
  logic       dst_clear;
  logic       dst_isolate_ack_q;
  logic       dst_clear_ack_q;
  logic       dst_valid;
  clr_phase_e src_phase;
  clr_phase_e dst_phase;

  // these three wires are the only paths between the two clock domains of the data path
  logic       async_req;
  logic       async_ack;
  cdc_word_t  async_data;

  // the sender never sees a valid while isolated, and the user never sees ready
  cdc_src_half i_src (
    .clk_i        (src_clk_i),
    .rst_ni       (src_rst_ni),
    .clear_i      (src_clear),
    .valid_i      (src_valid_i & ~src_isolate),
    .data_i       (src_data_i),
    .ready_o      (src_ready),
    .async_req_o  (async_req),
    .async_ack_i  (async_ack),
    .async_data_o (async_data)
  );

  assign src_ready_o = src_ready & ~src_isolate;

  // during isolation no word is offered to the user and none is consumed
  cdc_dst_half i_dst (
    .clk_i        (dst_clk_i),
    .rst_ni       (dst_rst_ni),
    .clear_i      (dst_clear),
    .ready_i      (dst_ready_i & ~dst_isolate),
    .data_o       (dst_data_o),
    .valid_o      (dst_valid),
    .async_req_i  (async_req),
    .async_ack_o  (async_ack),
    .async_data_i (async_data)
  );

  assign dst_valid_o = dst_valid & ~dst_isolate;

  // each sequencer watches the phase of its twin across the crossing
  cdc_clear_seq i_src_seq (
    .clk_i           (src_clk_i),
    .rst_ni          (src_rst_ni),
    .clear_i         (src_clear_i),
    .partner_phase_i (dst_phase),
    .phase_o         (src_phase),
    .isolate_o       (src_isolate),
    .clear_o         (src_clear),
    .isolate_ack_i   (src_isolate_ack_q),
    .clear_ack_i     (src_clear_ack_q)
  );

  cdc_clear_seq i_dst_seq (
    .clk_i           (dst_clk_i),
    .rst_ni          (dst_rst_ni),
    .clear_i         (dst_clear_i),
    .partner_phase_i (src_phase),
    .phase_o         (dst_phase),
    .isolate_o       (dst_isolate),
    .clear_o         (dst_clear),
    .isolate_ack_i   (dst_isolate_ack_q),
    .clear_ack_i     (dst_clear_ack_q)
  );

  // gating valid and ready takes effect at once and the toggle clear lands at
  // the next edge, so one cycle of delay is enough for both acknowledges
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      src_isolate_ack_q <= 1'b0;
      src_clear_ack_q   <= 1'b0;
    end else begin
      src_isolate_ack_q <= src_isolate;
      src_clear_ack_q   <= src_clear;
    end
  end

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      dst_isolate_ack_q <= 1'b0;
      dst_clear_ack_q   <= 1'b0;
    end else begin
      dst_isolate_ack_q <= dst_isolate;
      dst_clear_ack_q   <= dst_clear;
    end
  end

  assign src_clear_pending_o = src_isolate;
  assign dst_clear_pending_o = dst_isolate;

endmodule

// File: rtl/cdc_clear_seq.sv
// one side of the lock-step clear; partner_phase_i must come from the twin instance in the other domain
`timescale 1ns/1ps
`include "cdc_params.svh"

module cdc_clear_seq
  import cdc_ctrl_pkg::*;
#(
  parameter int unsigned SYNC_STAGES = `CDC_SYNC_STAGES
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  clr_phase_e partner_phase_i,
  output clr_phase_e phase_o,
  output logic       isolate_o,
  output logic       clear_o,
  input  logic       isolate_ack_i,
  input  logic       clear_ack_i
);

  localparam logic START_ON_RESET = `CDC_CLEAR_ON_ASYNC_RESET;

  clr_phase_e phase_d;
  clr_phase_e phase_q;
  clr_phase_e partner_phase;
  logic       partner_bit0;
  logic       partner_bit1;
  logic       start_q;
  logic       start_req;
  logic       partner_in_isolate;
  logic       partner_in_clear;
  logic       partner_in_post;
  logic       partner_in_idle;

  // each phase bit gets its own synchronizer, which is safe because the
  // partner changes one bit per step
  sync_ff #(
    .STAGES(SYNC_STAGES)
  ) i_phase_sync_0 (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .serial_i (partner_phase_i[0]),
    .serial_o (partner_bit0)
  );

  sync_ff #(
    .STAGES(SYNC_STAGES)
  ) i_phase_sync_1 (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .serial_i (partner_phase_i[1]),
    .serial_o (partner_bit1)
  );

  assign partner_phase = clr_phase_e'({partner_bit1, partner_bit0});

  assign partner_in_isolate = (partner_phase == phase_isolate);
  assign partner_in_clear   = (partner_phase == phase_clear);
  assign partner_in_post    = (partner_phase == phase_post_clear);
  assign partner_in_idle    = (partner_phase == phase_idle);

  // high only in the first cycle after reset, and only with the async option,
  // so that a one-sided reset drags the partner through a full clear too
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= START_ON_RESET;
    end else begin
      start_q <= 1'b0;
    end
  end

  // the partner leaving idle shows up here as isolate
  assign start_req = clear_i || partner_in_isolate || start_q;

  // a step is taken only once the partner is seen in the same or the next step,
  // which keeps the two sides at most one step apart
  // a partner reset jumps its phase from clear straight to idle, two bits at once,
  // so the synchronized copy may briefly read isolate or post_clear
  // seeing isolate while in post_clear therefore restarts the sequence, since the
  // partner has come out of reset and is waiting for us
  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      phase_idle: begin
        if (start_req) begin
          phase_d = phase_isolate;
        end
      end
      phase_isolate: begin
        // valid and ready are already forced low once the ack is back
        if (isolate_ack_i && (partner_in_isolate || partner_in_clear)) begin
          phase_d = phase_clear;
        end
      end
      phase_clear: begin
        // the toggle registers took the clear once the ack is back
        if (clear_ack_i && (partner_in_clear || partner_in_post)) begin
          phase_d = phase_post_clear;
        end
      end
      phase_post_clear: begin
        if (clear_i || partner_in_isolate) begin
          phase_d = phase_isolate;
        end else if (partner_in_post || partner_in_idle) begin
          phase_d = phase_idle;
        end
      end
      default: begin
        phase_d = phase_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= phase_idle;
    end else begin
      phase_q <= phase_d;
    end
  end

  assign phase_o   = phase_q;
  // isolation holds over the whole sequence, not only during the isolate step
  assign isolate_o = (phase_q != phase_idle);
  assign clear_o   = (phase_q == phase_clear);

endmodule

// File: rtl/cdc_ctrl_pkg.sv
// clear sequencer phases; the Gray order idle, isolate, clear, post_clear must be kept as it is
package cdc_ctrl_pkg;

  // every normal step flips exactly one bit, so the partner domain can sample the
  // phase through one plain synchronizer per bit without seeing a phase that was
  // never driven
  // the cycle is idle -> isolate -> clear -> post_clear -> idle
  typedef enum logic [1:0] {
    phase_idle       = 2'b00,
    phase_isolate    = 2'b01,
    phase_clear      = 2'b11,
    phase_post_clear = 2'b10
  } clr_phase_e;

endpackage

// File: rtl/cdc_data_pkg.sv
// payload type only; its width follows CDC_DATA_WIDTH and is identical in both clock domains
`include "cdc_params.svh"

package cdc_data_pkg;

  // only one word is in flight at any time, so a single plain vector carries it
  // and the hold register in the source half keeps it stable across the crossing
  typedef logic [`CDC_DATA_WIDTH-1:0] cdc_word_t;

endpackage

// File: rtl/cdc_dst_half.sv
// destination half of the crossing; async_data_i must be stable while the request toggle settles
`timescale 1ns/1ps
`include "cdc_params.svh"

module cdc_dst_half
  import cdc_data_pkg::*;
#(
  parameter int unsigned SYNC_STAGES = `CDC_SYNC_STAGES
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      ready_i,
  output cdc_word_t data_o,
  output logic      valid_o,
  input  logic      async_req_i,
  output logic      async_ack_o,
  input  cdc_word_t async_data_i
);

  logic      ack_d;
  logic      ack_q;
  logic      req_synced;
  logic      req_synced_q;
  logic      req_edge;
  cdc_word_t data_d;
  cdc_word_t data_q;

  // bring the request toggle from the source into this domain
  sync_ff #(
    .STAGES(SYNC_STAGES)
  ) i_req_sync (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .serial_i (async_req_i),
    .serial_o (req_synced)
  );

  // a fresh word shows up as a change of the synchronized request
  assign req_edge = (req_synced != req_synced_q);

  // the acknowledge flips once for every word the user takes, and a clear
  // brings it back to zero together with the source request toggle
  always_comb begin
    ack_d = ack_q;
    if (clear_i) begin
      ack_d = 1'b0;
    end else if (valid_o && ready_i) begin
      ack_d = ~ack_q;
    end
  end

  // capture only while nothing is pending, so a stalled word keeps its value
  // until the user takes it
  always_comb begin
    data_d = data_q;
    if (req_edge && !valid_o) begin
      data_d = async_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q        <= 1'b0;
      req_synced_q <= 1'b0;
    end else begin
      ack_q        <= ack_d;
      req_synced_q <= req_synced;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;
  end

  // valid comes up in the cycle after the capture, when the delayed request
  // has caught up and differs from the acknowledge
  assign valid_o     = (ack_q != req_synced_q);
  assign data_o      = data_q;
  assign async_ack_o = ack_q;

endmodule

// File: rtl/cdc_params.svh
// shared macros for the crossing; the sync depth must stay at 3 or more while clear on async reset is 1
`ifndef CDC_PARAMS_SVH
`define CDC_PARAMS_SVH

// depth of every synchronizer chain, both in the data path and in the clear sequencer
`define CDC_SYNC_STAGES 3

// width of the payload word carried from the source to the destination domain
`define CDC_DATA_WIDTH 32

// 1 makes an async reset on one side start the lock-step clear on the other side as well
`define CDC_CLEAR_ON_ASYNC_RESET 1

`endif

// File: rtl/cdc_src_half.sv
// source half of the crossing; valid_i must be low while clear_i is high, one word in flight at most
`timescale 1ns/1ps
`include "cdc_params.svh"

module cdc_src_half
  import cdc_data_pkg::*;
#(
  parameter int unsigned SYNC_STAGES = `CDC_SYNC_STAGES
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      valid_i,
  input  cdc_word_t data_i,
  output logic      ready_o,
  output logic      async_req_o,
  input  logic      async_ack_i,
  output cdc_word_t async_data_o
);

  logic      req_d;
  logic      req_q;
  logic      ack_synced;
  cdc_word_t data_d;
  cdc_word_t data_q;

  // bring the acknowledge toggle from the destination into this domain
  sync_ff #(
    .STAGES(SYNC_STAGES)
  ) i_ack_sync (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .serial_i (async_ack_i),
    .serial_o (ack_synced)
  );

  // a clear forces the request toggle back to zero, the destination half clears
  // its acknowledge toggle in the same sequence so both sides meet at zero again
  // an accepted word flips the request and is latched for the whole flight
  always_comb begin
    req_d  = req_q;
    data_d = data_q;
    if (clear_i) begin
      req_d = 1'b0;
    end else if (valid_i && ready_o) begin
      req_d  = ~req_q;
      data_d = data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req_d;
    end
  end

  // the destination only samples this register after the request toggle has
  // passed its synchronizer, so the word is long stable by then
  always_ff @(posedge clk_i) begin
    data_q <= data_d;
  end

  // equal toggles mean the last word came back acknowledged
  assign ready_o      = (req_q == ack_synced);
  assign async_req_o  = req_q;
  assign async_data_o = data_q;

endmodule

// File: rtl/sync_ff.sv
// one-bit level synchronizer; STAGES must be 2 or more and the input must hold for several clk_i cycles
`timescale 1ns/1ps
`include "cdc_params.svh"

module sync_ff #(
  parameter int unsigned STAGES = `CDC_SYNC_STAGES
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic serial_i,
  output logic serial_o
);

  // the first flop may go metastable, the later ones give it time to settle
  logic [STAGES-1:0] chain_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chain_q <= '0;
    end else begin
      chain_q <= {chain_q[STAGES-2:0], serial_i};
    end
  end

  // the last flop is the settled copy, exactly STAGES cycles behind serial_i
  assign serial_o = chain_q[STAGES-1];

endmodule

// File: tests/tb_cdc_tasks.svh
// checks and directed tests of tb_cdc; every wait gives up after WAIT_LIMIT source cycles
`ifndef TB_CDC_TASKS_SVH
`define TB_CDC_TASKS_SVH

task automatic check_word(input cdc_word_t actual, input cdc_word_t expected, input string what);
  if (actual !== expected) begin
    value_errors++;
    $display("ERR @ %0t: %s is %h, expected %h", $realtime, what, actual, expected);
  end
endtask

task automatic check_flag(input logic actual, input logic expected, input string what);
  if (actual !== expected) begin
    value_errors++;
    $display("ERR @ %0t: %s is %b, expected %b", $realtime, what, actual, expected);
  end
endtask

// one waited cycle, and the end of the run once the limit is used up
task automatic count_wait_cycle(inout int cnt, input string what);
  cnt++;
  if (cnt > WAIT_LIMIT) begin
    other_failures++;
    $display("timeout waiting for %s at %0t", what, $realtime);
    finish_run();
  end
endtask

// bookkeeping moves on a rising source edge, away from every checker
task automatic reset_scoreboard(input logic strict_mode);
  @(posedge src_clk);
  strict_order = strict_mode;
  sent_q.delete();
  recv_q.delete();
endtask

// ready comes from flops only, so its level at the falling edge decides the
// handshake on the following rising edge
task automatic send_word(input cdc_word_t word);
  int cnt;
  cnt = 0;
  @(negedge src_clk);
  src_valid = 1'b1;
  src_data  = word;
  while (!src_ready) begin
    @(negedge src_clk);
    count_wait_cycle(cnt, "src_ready_o to accept a word");
  end
  @(posedge src_clk);
  sent_q.push_back(word);
  @(negedge src_clk);
  src_valid = 1'b0;
endtask

// ready returns only after the acknowledge, so by then the last word was taken
task automatic drain(input string what);
  int cnt;
  cnt = 0;
  while (!src_ready) begin
    @(negedge src_clk);
    count_wait_cycle(cnt, {"the last word of ", what});
  end
endtask

task automatic send_words(input int count);
  cdc_word_t w;
  int        i;
  for (i = 0; i < count; i++) begin
    next_word(w);
    send_word(w);
  end
endtask

task automatic wait_clear_start(input string what);
  int cnt;
  cnt = 0;
  while (!(src_pending || dst_pending)) begin
    @(negedge src_clk);
    count_wait_cycle(cnt, {what, " to start"});
  end
endtask

task automatic wait_clear_end(input string what);
  int cnt;
  cnt = 0;
  while (src_pending || dst_pending) begin
    @(negedge src_clk);
    count_wait_cycle(cnt, {what, " to finish"});
  end
  cnt = 0;
  while (!src_ready) begin
    @(negedge src_clk);
    count_wait_cycle(cnt, {"src_ready_o after ", what});
  end
endtask

task automatic compare_streams(input string what);
  int i;
  if (recv_q.size() != sent_q.size()) begin
    other_failures++;
    $display("%s: %0d words delivered for %0d sent", what, recv_q.size(), sent_q.size());
  end
  for (i = 0; i < recv_q.size() && i < sent_q.size(); i++) begin
    check_word(recv_q[i], sent_q[i], {what, " beat"});
  end
endtask

// only the first word was in flight at the clear, so it alone may be missing
task automatic compare_lossy(input string what);
  int skip;
  int i;
  skip = sent_q.size() - recv_q.size();
  if (skip < 0 || skip > 1) begin
    other_failures++;
    $display("%s: %0d words delivered for %0d sent", what, recv_q.size(), sent_q.size());
  end else begin
    for (i = 0; i < recv_q.size(); i++) begin
      check_word(recv_q[i], sent_q[i + skip], {what, " beat"});
    end
  end
endtask

task automatic test_streaming();
  reset_scoreboard(1'b1);
  send_words(20);
  drain("streaming");
  compare_streams("streaming");
endtask

task automatic test_back_pressure();
  reset_scoreboard(1'b1);
  bp_on = 1'b1;
  send_words(20);
  drain("back-pressure");
  bp_on = 1'b0;
  compare_streams("back-pressure");
endtask

task automatic test_src_clear();
  int   cnt;
  logic seen_src;
  logic seen_dst;
  reset_scoreboard(1'b1);
  @(negedge src_clk);
  src_clear = 1'b1;
  @(negedge src_clk);
  src_clear = 1'b0;
  // both sides must take part in the clear, not only the one that asked
  cnt      = 0;
  seen_src = 1'b0;
  seen_dst = 1'b0;
  while (!(seen_src && seen_dst)) begin
    @(negedge src_clk);
    count_wait_cycle(cnt, "both clear pending outputs to rise");
    if (src_pending) begin
      seen_src = 1'b1;
    end
    if (dst_pending) begin
      seen_dst = 1'b1;
    end
  end
  wait_clear_end("the source clear");
  check_flag(recv_q.size() != 0, 1'b0, "a dst beat during the source clear");
  send_words(5);
  drain("transfers after the source clear");
  compare_streams("after the source clear");
endtask

task automatic test_dst_clear_mid_word();
  reset_scoreboard(1'b0);
  send_words(1);
  @(negedge dst_clk);
  dst_clear = 1'b1;
  @(negedge dst_clk);
  dst_clear = 1'b0;
  wait_clear_start("the destination clear");
  wait_clear_end("the destination clear");
  send_words(5);
  drain("transfers after the destination clear");
  compare_lossy("after the destination clear");
endtask

task automatic test_dst_async_reset();
  int cnt;
  reset_scoreboard(1'b1);
  @(negedge dst_clk);
  dst_rst_n = 1'b0;
  repeat (2) @(negedge dst_clk);
  dst_rst_n = 1'b1;
  // the source side is dragged into the clear by the reset of its partner
  cnt = 0;
  while (!src_pending) begin
    @(negedge src_clk);
    count_wait_cycle(cnt, "src_clear_pending_o after the destination reset");
  end
  wait_clear_end("the clear after the destination reset");
  check_flag(recv_q.size() != 0, 1'b0, "a dst beat after the destination reset");
  send_words(5);
  drain("transfers after the destination reset");
  compare_streams("after the destination reset");
endtask

`endif

// File: tests/tb_cdc.sv
// testbench for the clearable crossing; it stops at the first timeout and keeps one word in flight
`timescale 1ns/1ps

module tb_cdc
  import cdc_data_pkg::*;
();

  localparam logic [31:0] SEED       = 32'h3431eed1;
  localparam int          WAIT_LIMIT = 500;

  logic        src_clk;
  logic        dst_clk;
  logic        src_rst_n;
  logic        dst_rst_n;
  logic        src_clear;
  logic        src_valid;
  cdc_word_t   src_data;
  logic        src_ready;
  logic        src_pending;
  logic        dst_clear;
  logic        dst_ready = 1'b0;
  cdc_word_t   dst_word;
  logic        dst_valid;
  logic        dst_pending;

  // scoreboard of accepted source words and of words taken at the destination
  cdc_word_t   sent_q[$];
  cdc_word_t   recv_q[$];
  logic [31:0] data_state;
  // the gap generator runs on its own state so it never competes with the data stream
  logic [31:0] gap_state = ~SEED;
  logic        bp_on = 1'b0;
  logic        strict_order = 1'b1;
  int          value_errors = 0;
  int          other_failures = 0;

  initial begin
    src_clk = 1'b0;
    forever #2 src_clk = ~src_clk;
  end

  // half a nanosecond of offset keeps the two clocks from ever sharing an edge
  initial begin
    dst_clk = 1'b0;
    #0.5;
    forever #3 dst_clk = ~dst_clk;
  end

  cdc_2phase_clearable uut (
    .src_clk_i           (src_clk),
    .src_rst_ni          (src_rst_n),
    .src_clear_i         (src_clear),
    .src_valid_i         (src_valid),
    .src_data_i          (src_data),
    .src_ready_o         (src_ready),
    .src_clear_pending_o (src_pending),
    .dst_clk_i           (dst_clk),
    .dst_rst_ni          (dst_rst_n),
    .dst_clear_i         (dst_clear),
    .dst_ready_i         (dst_ready),
    .dst_data_o          (dst_word),
    .dst_valid_o         (dst_valid),
    .dst_clear_pending_o (dst_pending)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_word(output cdc_word_t w);
    data_state = xorshift32(data_state);
    w = data_state;
  endtask

  task automatic finish_run();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_failures);
    if (value_errors == 0 && other_failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  `include "tb_cdc_tasks.svh"

  // destination side: ready is chosen at the falling edge and the beat it
  // allows is recorded right away, since it lands on the next rising edge
  always @(negedge dst_clk) begin
    if (bp_on) begin
      gap_state = xorshift32(gap_state);
      dst_ready = (gap_state[1:0] == 2'b00);
    end else begin
      dst_ready = 1'b1;
    end
    if (dst_rst_n && dst_valid && dst_ready) begin
      if ($isunknown(dst_word)) begin
        value_errors++;
        $display("ERR @ %0t: dst_data_o carries unknown bits %h", $realtime, dst_word);
      end
      recv_q.push_back(dst_word);
    end else if (strict_order && dst_valid && recv_q.size() < sent_q.size()) begin
      // a stalled word has to be the oldest one not yet taken
      check_word(dst_word, sent_q[recv_q.size()], "dst_data_o while stalled");
    end
    if (dst_pending) begin
      check_flag(dst_valid, 1'b0, "dst_valid_o during a clear");
    end
  end

  // source side: no ready during a clear, and none while the last word is still out
  always @(negedge src_clk) begin
    if (src_pending) begin
      check_flag(src_ready, 1'b0, "src_ready_o during a clear");
    end
    if (strict_order && sent_q.size() > recv_q.size()) begin
      check_flag(src_ready, 1'b0, "src_ready_o with a word in flight");
    end
  end

  initial begin
    $timeformat(-9, 1, " ns", 0);
    src_rst_n  = 1'b0;
    dst_rst_n  = 1'b0;
    src_clear  = 1'b0;
    src_valid  = 1'b0;
    src_data   = '0;
    dst_clear  = 1'b0;
    data_state = SEED;
    repeat (10) @(posedge src_clk);
    @(negedge src_clk);
    // nothing may be pending or offered while both sides are held in reset
    check_flag(src_pending, 1'b0, "src_clear_pending_o in reset");
    check_flag(dst_pending, 1'b0, "dst_clear_pending_o in reset");
    check_flag(dst_valid, 1'b0, "dst_valid_o in reset");
    src_rst_n = 1'b1;
    dst_rst_n = 1'b1;
    // leaving reset runs one full clear on both sides
    wait_clear_start("the clear after reset");
    wait_clear_end("the clear after reset");
    test_streaming();
    test_back_pressure();
    test_src_clear();
    test_dst_clear_mid_word();
    test_dst_async_reset();
    finish_run();
  end

endmodule
